//--- logic/serial_pkg.sv
package serial_pkg;

   // ------------------------------------------------------------
   // Basic types
   // ------------------------------------------------------------
   typedef logic [31:0] word_t;
   typedef logic [4:0]  regaddr_t;
   typedef logic [4:0]  cnt_t;     // Bit index, 0 is the LSB.

   // ------------------------------------------------------------
   // Major opcodes of the supported RV32I subset
   // ------------------------------------------------------------
   typedef enum logic [6:0] {
      OP_IMM    = 7'b0010011,
      OP_REG    = 7'b0110011,
      OP_LUI    = 7'b0110111,
      OP_LOAD   = 7'b0000011,
      OP_STORE  = 7'b0100011,
      OP_BRANCH = 7'b1100011,
      OP_JAL    = 7'b1101111
   } opcode_e;

   typedef enum logic [2:0] {
      ALU_ADD = 3'd0,
      ALU_SUB = 3'd1,
      ALU_AND = 3'd2,
      ALU_OR  = 3'd3,
      ALU_XOR = 3'd4
   } alu_op_e;

   // Where the serial rd bit comes from.
   typedef enum logic [1:0] {
      RD_ALU  = 2'd0,
      RD_LINK = 2'd1,
      RD_MEM  = 2'd2,
      RD_IMM  = 2'd3
   } rd_src_e;

endpackage

//--- logic/serial_dp_if.sv
`timescale 1ns/10ps

interface serial_dp_if import serial_pkg::*; ();

   cnt_t     cnt;
   logic     en;          // EXEC or LOAD_WB.
   logic     init;        // First EXEC bit.
   logic     imm_bit;
   logic     op_b_imm;
   alu_op_e  alu_op;
   rd_src_e  rd_src;
   logic     rd_we;
   regaddr_t rs1_addr;
   regaddr_t rs2_addr;
   regaddr_t rd_addr;
   logic     branch;
   logic     jal;
   logic     branch_ne;
   logic     mem_start;   // Pulse on the last EXEC bit of LW/SW.
   logic     mem_we;

   modport ctl (
      output cnt, en, init, imm_bit, op_b_imm, alu_op, rd_src, rd_we,
      output rs1_addr, rs2_addr, rd_addr, branch, jal, branch_ne, mem_start, mem_we
   );

   modport dp (
      input cnt, en, init, imm_bit, op_b_imm, alu_op, rd_src, rd_we,
      input rs1_addr, rs2_addr, rd_addr, branch, jal, branch_ne, mem_start, mem_we
   );

endinterface

//--- logic/core_control.sv
`timescale 1ns/10ps

module core_control import serial_pkg::*; (
   input  logic  clk,
   input  logic  i_arst_n,
   input  word_t i_ibus_rdt,
   input  logic  i_ibus_ack,
   output logic  o_ibus_cyc,
   input  logic  i_cmp_eq,
   input  logic  i_mem_done,
   serial_dp_if.ctl dp
);

   typedef enum logic [2:0] {S_FETCH, S_DECODE, S_EXEC, S_MEM, S_LOAD_WB} state_e;

   state_e     state;
   cnt_t       cnt;
   logic       ibus_cyc;
   word_t      ir;
   word_t      imm_sr;
   word_t      imm_word;
   opcode_e    opcode;
   logic [2:0] funct3;
   logic       alu_ok;
   logic       is_mem;
   logic       is_branch;
   logic       last;

   assign opcode    = opcode_e'(ir[6:0]);
   assign funct3    = ir[14:12];
   assign last      = (cnt == cnt_t'(31));
   assign is_mem    = (opcode == OP_LOAD) || (opcode == OP_STORE);
   assign is_branch = (opcode == OP_BRANCH) && (funct3[2:1] == 2'b00);  // BEQ/BNE only.
   assign alu_ok    = ((opcode == OP_IMM) || (opcode == OP_REG)) &&
                      ((funct3 == 3'b000) || (funct3[2:1] == 2'b11) || (funct3 == 3'b100));

   // ------------------------------------------------------------
   // Decode
   // ------------------------------------------------------------
   always_comb begin
      case (funct3)
         3'b100:  dp.alu_op = ALU_XOR;
         3'b110:  dp.alu_op = ALU_OR;
         3'b111:  dp.alu_op = ALU_AND;
         default: dp.alu_op = (opcode == OP_REG && ir[30]) ? ALU_SUB : ALU_ADD;
      endcase
      if (is_mem || opcode == OP_BRANCH) dp.alu_op = ALU_ADD;
   end

   always_comb begin
      case (opcode)
         OP_STORE:  imm_word = {{20{ir[31]}}, ir[31:25], ir[11:7]};
         OP_BRANCH: imm_word = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
         OP_LUI:    imm_word = {ir[31:12], 12'd0};
         OP_JAL:    imm_word = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
         default:   imm_word = {{20{ir[31]}}, ir[31:20]};
      endcase
   end

   assign dp.cnt       = cnt;
   assign dp.en        = (state == S_EXEC) || (state == S_LOAD_WB);
   assign dp.init      = (state == S_EXEC) && (cnt == '0);
   assign dp.imm_bit   = imm_sr[0];
   assign dp.op_b_imm  = (opcode == OP_IMM) || is_mem;
   assign dp.rs1_addr  = ir[19:15];
   assign dp.rs2_addr  = ir[24:20];
   assign dp.rd_addr   = ir[11:7];
   assign dp.branch    = is_branch;
   assign dp.branch_ne = funct3[0];
   assign dp.jal       = (opcode == OP_JAL);
   assign dp.mem_start = (state == S_EXEC) && last && is_mem;
   assign dp.mem_we    = (opcode == OP_STORE);
   assign dp.rd_we     = (state == S_LOAD_WB) ||
                         (alu_ok || opcode == OP_LUI || opcode == OP_JAL);

   always_comb begin
      if (state == S_LOAD_WB)   dp.rd_src = RD_MEM;
      else if (opcode == OP_JAL) dp.rd_src = RD_LINK;
      else if (opcode == OP_LUI) dp.rd_src = RD_IMM;
      else                       dp.rd_src = RD_ALU;
   end

   assign o_ibus_cyc = ibus_cyc;

   // ------------------------------------------------------------
   // State machine and bit counter
   // ------------------------------------------------------------
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         state    <= S_FETCH;
         cnt      <= '0;
         ibus_cyc <= 1'b0;
      end else begin
         if (dp.en) cnt <= cnt + cnt_t'(1);
         case (state)
            S_FETCH: begin
               if (ibus_cyc && i_ibus_ack) begin
                  ibus_cyc <= 1'b0;
                  state    <= S_DECODE;
               end else begin
                  ibus_cyc <= 1'b1;
               end
            end
            S_DECODE:  state <= S_EXEC;
            S_EXEC:    if (last) state <= is_mem ? S_MEM : S_FETCH;
            S_MEM:     if (i_mem_done) state <= (opcode == OP_LOAD) ? S_LOAD_WB : S_FETCH;
            S_LOAD_WB: if (last) state <= S_FETCH;
            default:   state <= S_FETCH;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (ibus_cyc && i_ibus_ack) ir <= i_ibus_rdt;
      if (state == S_DECODE) imm_sr <= imm_word;
      else if (state == S_EXEC) imm_sr <= {imm_sr[31], imm_sr[31:1]};  // Sign stays.
   end

   a_ibus_hold: assert property (@(posedge clk) disable iff (!i_arst_n)
      (o_ibus_cyc && !i_ibus_ack) |=> o_ibus_cyc)
      else $error("ibus cyc dropped before ack");

   // Idle cycles leave the counter parked at bit 0.
   a_cnt_idle: assert property (@(posedge clk) disable iff (!i_arst_n)
      !dp.en |=> (cnt == '0))
      else $error("bit counter moved outside a serial phase");

   // The compare flag is built over all 32 bits from register data.
   a_cmp_known: assert property (@(posedge clk) disable iff (!i_arst_n)
      (state == S_EXEC && last && is_branch) |-> !$isunknown(i_cmp_eq))
      else $error("branch compare unknown at bit 31");

endmodule

//--- logic/core_alu.sv
`timescale 1ns/10ps

module core_alu import serial_pkg::*; (
   input  logic clk,
   input  logic i_arst_n,
   serial_dp_if.dp dp,
   input  logic i_rs1_bit,
   input  logic i_rs2_bit,
   output logic o_rd_bit,
   output logic o_cmp_eq
);

   logic op_b;
   logic sub;
   logic b_inv;
   logic c_in;
   logic sum;
   logic carry_r;
   logic eq_r;

   assign op_b  = dp.op_b_imm ? dp.imm_bit : i_rs2_bit;
   assign sub   = (dp.alu_op == ALU_SUB);
   assign b_inv = op_b ^ sub;
   assign c_in  = dp.init ? sub : carry_r;   // Subtract is A + ~B + 1.
   assign sum   = i_rs1_bit ^ b_inv ^ c_in;

   // Starts set and clears on the first differing bit.
   assign o_cmp_eq = (dp.init | eq_r) & ~(i_rs1_bit ^ op_b);

   always_comb begin
      case (dp.alu_op)
         ALU_AND: o_rd_bit = i_rs1_bit & op_b;
         ALU_OR:  o_rd_bit = i_rs1_bit | op_b;
         ALU_XOR: o_rd_bit = i_rs1_bit ^ op_b;
         default: o_rd_bit = sum;
      endcase
   end

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         carry_r <= 1'b0;
         eq_r    <= 1'b1;
      end else if (dp.en) begin
         carry_r <= (i_rs1_bit & b_inv) | (c_in & (i_rs1_bit ^ b_inv));
         eq_r    <= o_cmp_eq;
      end
   end

endmodule

//--- logic/core_regfile.sv
`timescale 1ns/10ps

module core_regfile import serial_pkg::*; (
   input  logic clk,
   input  logic i_arst_n,
   serial_dp_if.dp dp,
   input  logic i_rd_bit,
   output logic o_rs1_bit,
   output logic o_rs2_bit
);

   word_t regs [32];   // Entry 0 is never written.
   logic  wr_en;

   assign wr_en = dp.en && dp.rd_we && (dp.rd_addr != '0);

   // ------------------------------------------------------------
   // Serial write, one bit of rd per cycle
   // ------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (wr_en) begin
         regs[dp.rd_addr][dp.cnt] <= i_rd_bit;
      end
   end

   // ------------------------------------------------------------
   // Serial read
   // ------------------------------------------------------------
   // Bit cnt is read before the same bit is written, so rd may equal rs.
   assign o_rs1_bit = (dp.rs1_addr != '0) && regs[dp.rs1_addr][dp.cnt];
   assign o_rs2_bit = (dp.rs2_addr != '0) && regs[dp.rs2_addr][dp.cnt];

   a_x0_zero: assert property (@(posedge clk) disable iff (!i_arst_n)
      (dp.en && dp.rd_we && dp.rd_addr == '0) |=>
         ((dp.rs1_addr != '0 || !o_rs1_bit) && (dp.rs2_addr != '0 || !o_rs2_bit)))
      else $error("x0 read back nonzero");

endmodule

//--- logic/core_pc.sv
`timescale 1ns/10ps

module core_pc import serial_pkg::*; #(
   parameter word_t RESET_PC = 32'h0000_0000
) (
   input  logic  clk,
   input  logic  i_arst_n,
   serial_dp_if.dp dp,
   input  logic  i_cmp_eq,
   output word_t o_ibus_adr,
   output logic  o_link_bit
);

   word_t pc_r;
   word_t p4_sr;
   word_t tgt_sr;
   logic  step;
   logic  pc_bit;
   logic  four_bit;
   logic  p4_c;
   logic  p4_cin;
   logic  p4_bit;
   logic  tgt_c;
   logic  tgt_cin;
   logic  tgt_bit;
   logic  take;

   // Load write-back reuses the counter, the PC only steps in EXEC.
   assign step     = dp.en && (dp.rd_src != RD_MEM);
   assign pc_bit   = pc_r[dp.cnt];
   assign four_bit = (dp.cnt == cnt_t'(2));
   assign p4_cin   = dp.init ? 1'b0 : p4_c;
   assign tgt_cin  = dp.init ? 1'b0 : tgt_c;
   assign p4_bit   = pc_bit ^ four_bit ^ p4_cin;
   assign tgt_bit  = pc_bit ^ dp.imm_bit ^ tgt_cin;
   assign take     = dp.jal || (dp.branch && (i_cmp_eq ^ dp.branch_ne));

   assign o_ibus_adr = pc_r;
   assign o_link_bit = p4_bit;   // PC+4 for JAL.

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         pc_r  <= RESET_PC;
         p4_c  <= 1'b0;
         tgt_c <= 1'b0;
      end else if (step) begin
         p4_c  <= (pc_bit & four_bit) | (p4_cin & (pc_bit ^ four_bit));
         tgt_c <= (pc_bit & dp.imm_bit) | (tgt_cin & (pc_bit ^ dp.imm_bit));
         if (dp.cnt == cnt_t'(31)) begin
            pc_r <= take ? {tgt_bit, tgt_sr[31:1]} : {p4_bit, p4_sr[31:1]};
         end
      end
   end

   always_ff @(posedge clk) begin
      if (step) begin
         p4_sr  <= {p4_bit, p4_sr[31:1]};
         tgt_sr <= {tgt_bit, tgt_sr[31:1]};
      end
   end

endmodule

//--- logic/core_mem_if.sv
`timescale 1ns/10ps

module core_mem_if import serial_pkg::*; (
   input  logic       clk,
   input  logic       i_arst_n,
   serial_dp_if.dp    dp,
   input  logic       i_addr_bit,
   input  logic       i_rs2_bit,
   output logic       o_load_bit,
   output logic       o_mem_done,
   output word_t      o_dbus_adr,
   output word_t      o_dbus_dat,
   output logic [3:0] o_dbus_sel,
   output logic       o_dbus_we,
   output logic       o_dbus_cyc,
   input  word_t      i_dbus_rdt,
   input  logic       i_dbus_ack
);

   word_t adr_r;
   word_t dat_r;
   word_t rdt_r;
   logic  cyc_r;
   logic  we_r;
   logic  wb_phase;

   assign wb_phase = (dp.rd_src == RD_MEM);

   assign o_dbus_adr = adr_r;
   assign o_dbus_dat = dat_r;
   assign o_dbus_sel = 4'b1111;   // Word access only.
   assign o_dbus_we  = we_r;
   assign o_dbus_cyc = cyc_r;
   assign o_mem_done = cyc_r & i_dbus_ack;
   assign o_load_bit = rdt_r[0];

   // ------------------------------------------------------------
   // Bus cycle
   // ------------------------------------------------------------
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         cyc_r <= 1'b0;
         we_r  <= 1'b0;
      end else if (dp.mem_start) begin
         cyc_r <= 1'b1;
         we_r  <= dp.mem_we;
      end else if (cyc_r && i_dbus_ack) begin
         cyc_r <= 1'b0;
         we_r  <= 1'b0;
      end
   end

   // Address and store data arrive LSB first during EXEC.
   always_ff @(posedge clk) begin
      if (dp.en && !wb_phase) begin
         adr_r <= {i_addr_bit, adr_r[31:1]};
         dat_r <= {i_rs2_bit, dat_r[31:1]};
      end
      if (cyc_r && i_dbus_ack) rdt_r <= i_dbus_rdt;
      else if (dp.en && wb_phase) rdt_r <= {1'b0, rdt_r[31:1]};
   end

   a_dbus_stable: assert property (@(posedge clk) disable iff (!i_arst_n)
      (o_dbus_cyc && !i_dbus_ack) |=>
         ($stable(o_dbus_adr) && $stable(o_dbus_dat) && $stable(o_dbus_we)))
      else $error("dbus request changed while waiting for ack");

endmodule

//--- logic/core_top.sv
`timescale 1ns/10ps

module core_top import serial_pkg::*; #(
   parameter word_t RESET_PC = 32'h0000_0000
) (
   input  logic       clk,
   input  logic       i_arst_n,
   output word_t      o_ibus_adr,
   output logic       o_ibus_cyc,
   input  word_t      i_ibus_rdt,
   input  logic       i_ibus_ack,
   output word_t      o_dbus_adr,
   output word_t      o_dbus_dat,
   output logic [3:0] o_dbus_sel,
   output logic       o_dbus_we,
   output logic       o_dbus_cyc,
   input  word_t      i_dbus_rdt,
   input  logic       i_dbus_ack
);

   serial_dp_if dp_bus ();

   logic cmp_eq;
   logic rs1_bit;
   logic rs2_bit;
   logic alu_bit;
   logic link_bit;
   logic load_bit;
   logic mem_done;
   logic rd_bit;

   // ------------------------------------------------------------
   // rd bit source
   // ------------------------------------------------------------
   always_comb begin
      case (dp_bus.rd_src)
         RD_LINK: rd_bit = link_bit;
         RD_MEM:  rd_bit = load_bit;
         RD_IMM:  rd_bit = dp_bus.imm_bit;   // LUI.
         default: rd_bit = alu_bit;
      endcase
   end

   core_control u_control (
      .clk (clk), .i_arst_n (i_arst_n),
      .i_ibus_rdt (i_ibus_rdt), .i_ibus_ack (i_ibus_ack), .o_ibus_cyc (o_ibus_cyc),
      .i_cmp_eq (cmp_eq), .i_mem_done (mem_done), .dp (dp_bus.ctl)
   );

   core_alu u_alu (
      .clk (clk), .i_arst_n (i_arst_n), .dp (dp_bus.dp),
      .i_rs1_bit (rs1_bit), .i_rs2_bit (rs2_bit),
      .o_rd_bit (alu_bit), .o_cmp_eq (cmp_eq)
   );

   core_regfile u_regfile (
      .clk (clk), .i_arst_n (i_arst_n), .dp (dp_bus.dp),
      .i_rd_bit (rd_bit), .o_rs1_bit (rs1_bit), .o_rs2_bit (rs2_bit)
   );

   core_pc #(.RESET_PC (RESET_PC)) u_pc (
      .clk (clk), .i_arst_n (i_arst_n), .dp (dp_bus.dp),
      .i_cmp_eq (cmp_eq), .o_ibus_adr (o_ibus_adr), .o_link_bit (link_bit)
   );

   core_mem_if u_mem_if (
      .clk (clk), .i_arst_n (i_arst_n), .dp (dp_bus.dp),
      .i_addr_bit (alu_bit), .i_rs2_bit (rs2_bit),
      .o_load_bit (load_bit), .o_mem_done (mem_done),
      .o_dbus_adr (o_dbus_adr), .o_dbus_dat (o_dbus_dat), .o_dbus_sel (o_dbus_sel),
      .o_dbus_we (o_dbus_we), .o_dbus_cyc (o_dbus_cyc),
      .i_dbus_rdt (i_dbus_rdt), .i_dbus_ack (i_dbus_ack)
   );

endmodule

//--- test/tb_core.sv
`timescale 1ns/10ps

module tb_core import serial_pkg::*; ();

   localparam word_t      RESET_PC      = 32'h0000_0000;
   localparam word_t      MARKER_ADR    = 32'h0000_03F0;
   localparam logic [7:0] REC_BASE      = 8'hC0;   // Word index of the expected stores.
   localparam int         MAX_ACK_DELAY = 3;
   localparam int         N_EXEC        = 46;      // Executed instructions, loop included.
   localparam int         TIMEOUT       = N_EXEC * (3 * 32 + 4 * MAX_ACK_DELAY);

   logic       clk;
   logic       arst_n;
   word_t      ibus_adr;
   logic       ibus_cyc;
   word_t      ibus_rdt = '0;
   logic       ibus_ack = 1'b0;
   word_t      dbus_adr;
   word_t      dbus_dat;
   logic [3:0] dbus_sel;
   logic       dbus_we;
   logic       dbus_cyc;
   word_t      dbus_rdt = '0;
   logic       dbus_ack = 1'b0;

   word_t      mem [256];
   int         seed = 23;
   int         ibus_wait = 0;
   int         dbus_wait = 0;
   logic       ibus_busy = 1'b0;
   logic       dbus_busy = 1'b0;
   logic       fetch_seen = 1'b0;
   word_t      ibus_held;
   word_t      dbus_held_adr;
   word_t      dbus_held_dat;
   logic [7:0] rec_ptr = REC_BASE;
   int         store_cnt = 0;
   logic       run_done = 1'b0;

   core_top #(.RESET_PC (RESET_PC)) uut (
      .clk (clk), .i_arst_n (arst_n),
      .o_ibus_adr (ibus_adr), .o_ibus_cyc (ibus_cyc),
      .i_ibus_rdt (ibus_rdt), .i_ibus_ack (ibus_ack),
      .o_dbus_adr (dbus_adr), .o_dbus_dat (dbus_dat), .o_dbus_sel (dbus_sel),
      .o_dbus_we (dbus_we), .o_dbus_cyc (dbus_cyc),
      .i_dbus_rdt (dbus_rdt), .i_dbus_ack (dbus_ack)
   );

   // ------------------------------------------------------------
   // Error reporting and compares
   // ------------------------------------------------------------
   task automatic stop_on_error(input string msg);
      $display("%s", msg);
      $display("TEST FAILED");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check_word(input string name, input word_t exp, input word_t act);
      if (act !== exp)
         stop_on_error($sformatf("CHECK FAILED %s: expected data %08h, actual %08h",
                                 name, exp, act));
   endtask

   task automatic check_addr(input string name, input word_t exp, input word_t act);
      if (act !== exp)
         stop_on_error($sformatf("CHECK FAILED %s: expected address %08h, actual %08h",
                                 name, exp, act));
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp)
         stop_on_error($sformatf("CHECK FAILED %s: expected %b, actual %b", name, exp, act));
   endtask

   function automatic int next_delay();
      return $unsigned($random(seed)) % (MAX_ACK_DELAY + 1);
   endfunction

   // Each store must match the next (address, data) pair of the table.
   task automatic match_store();
      string name;
      name = $sformatf("store %0d", store_cnt);
      check_addr({name, " address"}, mem[rec_ptr], dbus_adr);
      check_word({name, " data"}, mem[rec_ptr + 8'd1], dbus_dat);
      if (dbus_adr == MARKER_ADR) run_done <= 1'b1;
      rec_ptr   = rec_ptr + 8'd2;
      store_cnt = store_cnt + 1;
   endtask

   // ------------------------------------------------------------
   // Instruction bus model
   // ------------------------------------------------------------
   always @(posedge clk) begin
      ibus_ack <= 1'b0;
      if (ibus_cyc && !ibus_ack) begin
         if (!fetch_seen) begin
            check_addr("first fetch", RESET_PC, ibus_adr);
            fetch_seen = 1'b1;
         end
         if (!ibus_busy) begin
            ibus_held = ibus_adr;
            ibus_busy = 1'b1;
         end
         check_addr("ibus hold", ibus_held, ibus_adr);
         if (ibus_wait == 0) begin
            ibus_ack  <= 1'b1;
            ibus_rdt  <= mem[ibus_adr[9:2]];
            ibus_busy = 1'b0;
            ibus_wait = next_delay();
         end else begin
            ibus_wait = ibus_wait - 1;   // Back-pressure.
         end
      end
   end

   // ------------------------------------------------------------
   // Data bus model
   // ------------------------------------------------------------
   always @(posedge clk) begin
      dbus_ack <= 1'b0;
      if (dbus_cyc && !dbus_ack) begin
         if (!dbus_busy) begin
            dbus_held_adr = dbus_adr;
            dbus_held_dat = dbus_dat;
            dbus_busy     = 1'b1;
         end
         check_addr("dbus hold", dbus_held_adr, dbus_adr);
         check_word("dbus hold", dbus_held_dat, dbus_dat);
         check_bit("dbus sel all ones", 1'b1, &dbus_sel);
         if (dbus_wait == 0) begin
            dbus_ack  <= 1'b1;
            dbus_busy = 1'b0;
            dbus_wait = next_delay();
            if (dbus_we) begin
               match_store();
               mem[dbus_adr[9:2]] <= dbus_dat;
            end else begin
               dbus_rdt <= mem[dbus_adr[9:2]];
            end
         end else begin
            dbus_wait = dbus_wait - 1;
         end
      end
   end

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   initial begin
      int cycle_cnt;
      arst_n    = 1'b0;
      cycle_cnt = 0;
      $readmemh("test/testdata_prog.hex", mem);
      repeat (4) begin
         @(posedge clk);
         check_bit("ibus cyc in reset", 1'b0, ibus_cyc);
         check_bit("dbus cyc in reset", 1'b0, dbus_cyc);
         check_bit("dbus we in reset", 1'b0, dbus_we);
      end
      arst_n <= 1'b1;
      @(posedge clk);
      check_bit("ibus cyc after reset", 1'b0, ibus_cyc);
      @(posedge clk);
      check_bit("ibus cyc on first fetch", 1'b1, ibus_cyc);
      while (!run_done && cycle_cnt < TIMEOUT) begin
         @(posedge clk);
         cycle_cnt = cycle_cnt + 1;
      end
      if (run_done) begin
         $display("TEST PASSED");
         $finish;
      end else begin
         stop_on_error($sformatf("Timeout: no store to the marker address in %0d cycles",
                                 TIMEOUT));
      end
   end

endmodule

//--- test/testdata_prog.hex
// Columns: 32-bit hex words, word addressed, four per line.
// @000 program, @080 load data, @0C0 expected stores as address then data pairs.
@000
5A300093 F0F00113 10000513 002081B3  // 00 operands, base, ADD
40208233 0020F2B3 0020E333 0020C3B3  // 10 SUB AND OR XOR
A0008413 ABCDE4B7 00352023 00452223  // 20 ADDI neg, LUI, stores
00552423 00652623 00752823 00852A23  // 30 stores
00952C23 20000593 0005A603 0045A683  // 40 store, data pointer, LW
0005A003 00C52E23 02D52023 02052223  // 50 LW x0, store loads
00208463 02152423 00209463 02252623  // 60 BEQ not taken, BNE taken
00318463 02252823 00109463 02452A23  // 70 BEQ taken, BNE not taken
00300793 00000813 00580813 FFF78793  // 80 loop setup and body
FE079CE3 03052C23 008008EF 02252E23  // 90 BNE back, JAL
05152023 3F000A13 001A2023 0000006F  // A0 link store, marker store
@080
9E3779B9 13572468
@0C0
00000100 000004B2 00000104 00000694
00000108 00000503 0000010C FFFFFFAF
00000110 FFFFFAAC 00000114 FFFFFFA3
00000118 ABCDE000 0000011C 9E3779B9
00000120 13572468 00000124 00000000
00000128 000005A3 00000134 00000694
00000138 0000000F 00000140 0000009C
000003F0 000005A3

//--- filelist.f
logic/serial_pkg.sv
logic/serial_dp_if.sv
logic/core_control.sv
logic/core_alu.sv
logic/core_regfile.sv
logic/core_pc.sv
logic/core_mem_if.sv
logic/core_top.sv
test/tb_core.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the core testbench with Verilator.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module tb_core -f filelist.f -o sim_core
./obj_dir/sim_core
